// File: sources.f
+incdir+include
hw/rv_pkg.sv
hw/regfile.sv
hw/fetch_stage.sv
hw/decoder_stage.sv
hw/execute_stage.sv
hw/fetch_execute.sv
tb/tb_fetch_execute.sv

// File: Makefile
TOP = tb_fetch_execute

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir

// File: tb/tb_fetch_execute.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module tb_fetch_execute;

    import rv_pkg::*;

    localparam int PROG_LEN     = 28;
    localparam int NUM_INIT     = 7;
    localparam int NUM_PROGS    = 6;
    localparam int RESET_CYCLES = 16;
    // each program gets reset, load, drain and 40 cycles per instruction
    localparam int LIMIT_CYCLES =
        NUM_PROGS * (PROG_LEN * 40 + `IMEM_DEPTH + RESET_CYCLES + 32);

    logic                    fe_clk;
    logic                    arst_n;
    logic                    ce;
    logic                    stall;
    logic                    flush;
    logic                    imem_we;
    logic [`IMEM_AWIDTH-1:0] imem_addr;
    logic [`XLEN-1:0]        imem_wdata;
    wb_t                     wb;
    redirect_t               redirect;
    logic [`XLEN-1:0]        alu_value;

    logic [31:0]      lfsr_state;
    logic [31:0]      prog [0:PROG_LEN-1];
    logic [31:0]      spin_pc;
    logic             stall_enable;
    logic             spin_ok;
    logic [`XLEN-1:0] alu_prev;
    wb_t              exp_wb[$];
    logic             exp_from_alu[$];
    redirect_t        exp_rd[$];

    fetch_execute u_fetch_execute (
        .fe_clk     (fe_clk),
        .arst_n     (arst_n),
        .ce         (ce),
        .stall      (stall),
        .flush      (flush),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb         (wb),
        .redirect   (redirect),
        .alu_value  (alu_value)
    );

    initial fe_clk = 1'b0;
    always #5 fe_clk = ~fe_clk;

    initial begin
        #(LIMIT_CYCLES * 10);
        $display("Verification failed");
        $fatal(1, "the run timed out before all programs finished");
    end

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // beyond the program every word jumps back to address 0
    function automatic logic [31:0] word_at(input logic [`IMEM_AWIDTH-1:0] a);
        if (int'(a) < PROG_LEN) begin
            return prog[a];
        end
        return enc_j(21'(-(int'(a) * 4)), 5'd0);
    endfunction

    function automatic void gen_program();
        logic [2:0] kind;
        logic [2:0] sel;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        int         k;
        for (int i = 0; i < NUM_INIT; i++) begin
            prog[i] = enc_i(12'(rand_bits(12)), 5'd0, 5'(i + 1));
        end
        for (int i = NUM_INIT; i < PROG_LEN - 1; i++) begin
            kind = 3'(rand_bits(3));
            rd   = 5'(rand_bits(3));
            rs1  = 5'(rand_bits(3));
            rs2  = 5'(rand_bits(3));
            k    = 1 + int'(rand_bits(2)) % 3;
            if (i + k > PROG_LEN - 1) begin
                k = PROG_LEN - 1 - i;
            end
            case (kind)
                3'd0, 3'd1, 3'd2: begin
                    sel = 3'(rand_bits(3));
                    case (sel)
                        3'd0, 3'd1: f3 = 3'b000;
                        3'd2:       f3 = 3'b111;
                        3'd3:       f3 = 3'b110;
                        3'd4:       f3 = 3'b100;
                        3'd5:       f3 = 3'b010;
                        3'd6:       f3 = 3'b001;
                        default:    f3 = 3'b101;
                    endcase
                    prog[i] = enc_r((sel == 3'd1) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd);
                end
                3'd3: prog[i] = enc_i(12'(rand_bits(12)), rs1, rd);
                3'd4: prog[i] = {20'(rand_bits(20)), rd, LUI};
                3'd5, 3'd6: begin
                    // equal sources make taken branches common
                    if (rand_bits(1) != 32'd0) begin
                        rs2 = rs1;
                    end
                    prog[i] = enc_b(13'(k * 4), rs2, rs1, {2'b00, kind[0]});
                end
                default: prog[i] = enc_j(21'(k * 4), rd);
            endcase
        end
        prog[PROG_LEN-1] = enc_j(21'd0, 5'd0);
        spin_pc          = 32'((PROG_LEN - 1) * 4);
    endfunction

    // architectural model, runs until a jump to itself
    function automatic void run_model(input logic [31:0] start_pc);
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        taken;
        wb_t         w;
        redirect_t   r;
        pc = start_pc;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int step = 0; step < 4 * PROG_LEN; step++) begin
            ins   = word_at(pc[`IMEM_AWIDTH+1:2]);
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            taken = 1'b0;
            res   = '0;
            imm   = '0;
            case (ins[6:0])
                OP: begin
                    case ({ins[30], ins[14:12]})
                        4'b0000: res = a + b;
                        4'b1000: res = a - b;
                        4'b0111: res = a & b;
                        4'b0110: res = a | b;
                        4'b0100: res = a ^ b;
                        4'b0010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        4'b0001: res = a << b[4:0];
                        default: res = a >> b[4:0];
                    endcase
                end
                OP_IMM: res = a + {{20{ins[31]}}, ins[31:20]};
                LUI:    res = {ins[31:12], 12'b0};
                BRANCH: begin
                    imm   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    taken = (a == b) ^ ins[12];
                end
                default: begin
                    imm   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                    res   = pc + 32'd4;
                    taken = 1'b1;
                end
            endcase
            if ((ins[6:0] != BRANCH) && (ins[11:7] != 5'd0)) begin
                w.we      = 1'b1;
                w.addr_rd = ins[11:7];
                w.data_rd = res;
                exp_wb.push_back(w);
                // the link value of a jump does not come from the alu
                exp_from_alu.push_back(ins[6:0] != JAL);
                regs[ins[11:7]] = res;
            end
            if (taken) begin
                r.change_pc = 1'b1;
                r.next_pc   = pc + imm;
                exp_rd.push_back(r);
                if (r.next_pc == pc) begin
                    return;
                end
                pc = r.next_pc;
            end else begin
                pc = pc + 32'd4;
            end
        end
    endfunction

    task automatic report_failure(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_alu(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("alu value %h, expected %h", got, exp));
        end
    endtask

    task automatic check_wb(input wb_t got, input logic [`XLEN-1:0] alu_got);
        wb_t  exp;
        logic from_alu;
        if (exp_wb.size() == 0) begin
            report_failure($sformatf("unexpected writeback x%0d=%h", got.addr_rd, got.data_rd));
        end else begin
            exp      = exp_wb.pop_front();
            from_alu = exp_from_alu.pop_front();
            if (got !== exp) begin
                report_failure($sformatf("writeback x%0d=%h, expected x%0d=%h",
                               got.addr_rd, got.data_rd, exp.addr_rd, exp.data_rd));
            end else if (from_alu) begin
                check_alu(alu_got, exp.data_rd);
            end
        end
    endtask

    task automatic check_redirect(input redirect_t got);
        redirect_t exp;
        if (exp_rd.size() == 0) begin
            // the closing self jump keeps spinning
            if (!(spin_ok && (got.next_pc == spin_pc))) begin
                report_failure($sformatf("unexpected redirect to %h", got.next_pc));
            end
        end else begin
            exp = exp_rd.pop_front();
            if (got !== exp) begin
                report_failure($sformatf("redirect to %h, expected %h",
                               got.next_pc, exp.next_pc));
            end
        end
    endtask

    // alu_prev holds the alu value from the last unstalled edge,
    // which is the one the current writeback was captured from
    always @(posedge fe_clk) begin
        if (arst_n) begin
            if (wb.we) begin
                check_wb(wb, alu_prev);
            end
            if (redirect.change_pc) begin
                check_redirect(redirect);
            end
            if (!stall) begin
                alu_prev = alu_value;
            end
        end
    end

    initial begin
        stall = 1'b0;
        forever begin
            @(negedge fe_clk);
            if (stall_enable) begin
                stall = (rand_bits(3) == 32'd0);
            end else begin
                stall = 1'b0;
            end
        end
    end

    // ce is first sampled high at E0 and the first writeback follows E3
    task automatic check_latency();
        repeat (3) @(posedge fe_clk);
        #1;
        if (wb.we) begin
            report_failure("writeback arrived before the third edge");
        end
        @(posedge fe_clk);
        #1;
        if (!wb.we || (wb.addr_rd != 5'd1)) begin
            report_failure("first writeback missing three edges after the fetch");
        end
    endtask

    task automatic wait_drained();
        do begin
            @(posedge fe_clk);
            #1;
        end while ((exp_wb.size() != 0) || (exp_rd.size() != 0));
    endtask

    task automatic run_program(input int p);
        @(negedge fe_clk);
        ce     = 1'b0;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge fe_clk);
        arst_n = 1'b1;
        gen_program();
        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            imem_we    = 1'b1;
            imem_addr  = 8'(a);
            imem_wdata = word_at(8'(a));
            @(negedge fe_clk);
        end
        imem_we = 1'b0;
        run_model(32'd0);
        spin_ok = 1'b0;
        @(posedge fe_clk);
        stall_enable = (p >= 2);
        @(negedge fe_clk);
        ce = 1'b1;
        if (p == 0) begin
            check_latency();
        end
        wait_drained();
        spin_ok      = 1'b1;
        stall_enable = 1'b0;
        // flush the fetch right behind a spin redirect, the fill jal restarts at 0
        do begin
            @(posedge fe_clk);
        end while (!redirect.change_pc);
        @(negedge fe_clk);
        flush   = 1'b1;
        spin_ok = 1'b0;
        run_model(spin_pc + 32'd4);
        @(negedge fe_clk);
        flush = 1'b0;
        @(posedge fe_clk);
        stall_enable = (p >= 2);
        wait_drained();
        spin_ok      = 1'b1;
        stall_enable = 1'b0;
        @(negedge fe_clk);
        ce = 1'b0;
        repeat (8) @(negedge fe_clk);
    endtask

    initial begin
        lfsr_state   = 32'h97a0;
        arst_n       = 1'b0;
        ce           = 1'b0;
        flush        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        stall_enable = 1'b0;
        spin_ok      = 1'b0;
        spin_pc      = '0;
        alu_prev     = '0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: hw/fetch_execute.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module fetch_execute (
    input  logic                    fe_clk,
    input  logic                    arst_n,
    input  logic                    ce,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    imem_we,
    input  logic [`IMEM_AWIDTH-1:0] imem_addr,
    input  logic [`XLEN-1:0]        imem_wdata,
    output rv_pkg::wb_t             wb,
    output rv_pkg::redirect_t       redirect,
    output logic [`XLEN-1:0]        alu_value
);

    import rv_pkg::*;

    logic [`XLEN-1:0]       instr;
    logic [`XLEN-1:0]       pc;
    logic                   instr_valid;
    logic [`REG_AWIDTH-1:0] addr_rs1;
    logic [`REG_AWIDTH-1:0] addr_rs2;
    logic [`XLEN-1:0]       data_rs1;
    logic [`XLEN-1:0]       data_rs2;
    ds_ex_t                 ds_ex;

    fetch_stage u_fetch_stage (
        .if_clk      (fe_clk),
        .arst_n      (arst_n),
        .ce          (ce),
        .stall       (stall),
        .flush       (flush),
        .redirect    (redirect),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid)
    );

    decoder_stage u_decoder_stage (
        .ds_clk      (fe_clk),
        .arst_n      (arst_n),
        .stall       (stall),
        .flush       (flush),
        .redirect    (redirect),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .addr_rs1    (addr_rs1),
        .addr_rs2    (addr_rs2),
        .data_rs1    (data_rs1),
        .data_rs2    (data_rs2),
        .ds_ex       (ds_ex)
    );

    // written from the execute writeback
    regfile u_regfile (
        .rf_clk   (fe_clk),
        .arst_n   (arst_n),
        .addr_rs1 (addr_rs1),
        .addr_rs2 (addr_rs2),
        .data_rs1 (data_rs1),
        .data_rs2 (data_rs2),
        .wb       (wb)
    );

    execute_stage u_execute_stage (
        .ex_clk    (fe_clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .ds_ex     (ds_ex),
        .wb        (wb),
        .redirect  (redirect),
        .alu_value (alu_value)
    );

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module execute_stage (
    input  logic               ex_clk,
    input  logic               arst_n,
    input  logic               stall,
    input  rv_pkg::ds_ex_t     ds_ex,
    output rv_pkg::wb_t        wb,
    output rv_pkg::redirect_t  redirect,
    output logic [`XLEN-1:0]   alu_value
);

    import rv_pkg::*;

    wb_t              wb_q;
    wb_t              wb_next;
    redirect_t        redirect_q;
    redirect_t        redirect_next;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_value;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic             live;
    logic             take;
    logic             writes_rd;

    // the slot right behind a taken branch or jump is dropped here
    assign live = ds_ex.valid && !redirect_q.change_pc;

    // forward the last registered writeback, which the register file
    // has not committed yet
    always_comb begin
        if (wb_q.we && (wb_q.addr_rd == ds_ex.addr_rs1)) begin
            op_a = wb_q.data_rd;
        end else begin
            op_a = ds_ex.data_rs1;
        end

        if (wb_q.we && (wb_q.addr_rd == ds_ex.addr_rs2)) begin
            rs2_value = wb_q.data_rd;
        end else begin
            rs2_value = ds_ex.data_rs2;
        end
    end

    assign op_b = ds_ex.use_imm ? ds_ex.imm : rs2_value;

    always_comb begin
        case (ds_ex.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            AND:     alu_result = op_a & op_b;
            OR:      alu_result = op_a | op_b;
            XOR:     alu_result = op_a ^ op_b;
            SLT:     alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLL:     alu_result = op_a << op_b[4:0];
            SRL:     alu_result = op_a >> op_b[4:0];
            PASS_B:  alu_result = op_b;
            default: alu_result = '0;
        endcase
    end

    assign alu_value = alu_result;

    always_comb begin
        // funct3 bit 0 selects bne over beq
        take      = 1'b0;
        writes_rd = 1'b0;
        case (ds_ex.opcode)
            OP, OP_IMM, LUI: writes_rd = 1'b1;
            BRANCH:          take = (alu_result == '0) ^ ds_ex.funct3[0];
            JAL: begin
                take      = 1'b1;
                writes_rd = 1'b1;
            end
            default: ;
        endcase

        wb_next.we      = live && writes_rd && (ds_ex.addr_rd != '0);
        wb_next.addr_rd = ds_ex.addr_rd;
        if (ds_ex.opcode == JAL) begin
            wb_next.data_rd = ds_ex.pc + `XLEN'(`PC_STEP);
        end else begin
            wb_next.data_rd = alu_result;
        end

        redirect_next.change_pc = live && take;
        redirect_next.next_pc   = ds_ex.pc + ds_ex.imm;
    end

    always_ff @(posedge ex_clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q       <= '0;
            redirect_q <= '0;
        end else if (!stall) begin
            wb_q       <= wb_next;
            redirect_q <= redirect_next;
        end
    end

    // held values stay visible under stall but their pulses are masked
    always_comb begin
        wb                 = wb_q;
        wb.we              = wb_q.we && !stall;
        redirect           = redirect_q;
        redirect.change_pc = redirect_q.change_pc && !stall;
    end

    a_single_redirect: assert property (
        @(posedge ex_clk) disable iff (!arst_n)
        redirect.change_pc |=> !redirect.change_pc
    ) else $error("change_pc high on two consecutive cycles");

endmodule

// File: hw/decoder_stage.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module decoder_stage (
    input  logic                   ds_clk,
    input  logic                   arst_n,
    input  logic                   stall,
    input  logic                   flush,
    input  rv_pkg::redirect_t      redirect,
    input  logic [`XLEN-1:0]       instr,
    input  logic [`XLEN-1:0]       pc,
    input  logic                   instr_valid,
    output logic [`REG_AWIDTH-1:0] addr_rs1,
    output logic [`REG_AWIDTH-1:0] addr_rs2,
    input  logic [`XLEN-1:0]       data_rs1,
    input  logic [`XLEN-1:0]       data_rs2,
    output rv_pkg::ds_ex_t         ds_ex
);

    import rv_pkg::*;

    logic [`FUNCT3_WIDTH-1:0] funct3;
    logic [`FUNCT7_WIDTH-1:0] funct7;
    logic [`XLEN-1:0]         imm_i;
    logic [`XLEN-1:0]         imm_u;
    logic [`XLEN-1:0]         imm_b;
    logic [`XLEN-1:0]         imm_j;
    logic                     supported;
    logic                     flush_any;
    ds_ex_t                   ds_next;

    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign flush_any = flush || redirect.change_pc;

    // source registers go straight to the register file
    assign addr_rs1 = instr[19:15];
    assign addr_rs2 = instr[24:20];

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        supported = 1'b1;
        ds_next          = '0;
        ds_next.opcode   = OP;
        ds_next.alu_op   = ADD;
        ds_next.funct3   = funct3;
        ds_next.pc       = pc;
        ds_next.addr_rs1 = addr_rs1;
        ds_next.addr_rs2 = addr_rs2;
        ds_next.addr_rd  = instr[11:7];
        ds_next.data_rs1 = data_rs1;
        ds_next.data_rs2 = data_rs2;

        case (instr[6:0])
            OP: begin
                ds_next.opcode = OP;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ds_next.alu_op = ADD;
                    {7'b0100000, 3'b000}: ds_next.alu_op = SUB;
                    {7'b0000000, 3'b111}: ds_next.alu_op = AND;
                    {7'b0000000, 3'b110}: ds_next.alu_op = OR;
                    {7'b0000000, 3'b100}: ds_next.alu_op = XOR;
                    {7'b0000000, 3'b010}: ds_next.alu_op = SLT;
                    {7'b0000000, 3'b001}: ds_next.alu_op = SLL;
                    {7'b0000000, 3'b101}: ds_next.alu_op = SRL;
                    default:              supported = 1'b0;
                endcase
            end
            OP_IMM: begin
                // only addi
                ds_next.opcode  = OP_IMM;
                ds_next.imm     = imm_i;
                ds_next.use_imm = 1'b1;
                supported       = (funct3 == 3'b000);
            end
            LUI: begin
                ds_next.opcode  = LUI;
                ds_next.alu_op  = PASS_B;
                ds_next.imm     = imm_u;
                ds_next.use_imm = 1'b1;
            end
            BRANCH: begin
                // beq and bne compare through a subtraction
                ds_next.opcode = BRANCH;
                ds_next.alu_op = SUB;
                ds_next.imm    = imm_b;
                supported      = (funct3 == 3'b000) || (funct3 == 3'b001);
            end
            JAL: begin
                ds_next.opcode = JAL;
                ds_next.imm    = imm_j;
            end
            default: supported = 1'b0;
        endcase

        ds_next.valid = instr_valid && supported && !flush_any;
    end

    always_ff @(posedge ds_clk or negedge arst_n) begin
        if (!arst_n) begin
            ds_ex <= '0;
        end else if (!stall) begin
            ds_ex <= ds_next;
        end
    end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module fetch_stage (
    input  logic                    if_clk,
    input  logic                    arst_n,
    input  logic                    ce,
    input  logic                    stall,
    input  logic                    flush,
    input  rv_pkg::redirect_t       redirect,
    input  logic                    imem_we,
    input  logic [`IMEM_AWIDTH-1:0] imem_addr,
    input  logic [`XLEN-1:0]        imem_wdata,
    output logic [`XLEN-1:0]        instr,
    output logic [`XLEN-1:0]        pc,
    output logic                    instr_valid
);

    logic [`XLEN-1:0] imem [0:`IMEM_DEPTH-1];

    // address of the pending request and whether it is a real fetch
    logic [`XLEN-1:0] fetch_pc;
    logic             req_valid;
    logic             flush_any;

    assign flush_any = flush || redirect.change_pc;

    // the request in fetch_pc is consumed on every edge that is not stalled,
    // so the pointer steps on whenever that request was live
    always_ff @(posedge if_clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc    <= '0;
            req_valid   <= 1'b0;
            instr_valid <= 1'b0;
        end else if (!stall) begin
            instr_valid <= req_valid && !flush_any;
            req_valid   <= ce;
            if (redirect.change_pc) begin
                fetch_pc <= redirect.next_pc;
            end else if (req_valid) begin
                fetch_pc <= fetch_pc + `XLEN'(`PC_STEP);
            end
        end
    end

    // load port for the program image
    always_ff @(posedge if_clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // synchronous read, word address taken from the byte pc
    always_ff @(posedge if_clk) begin
        if (!stall) begin
            instr <= imem[fetch_pc[`IMEM_AWIDTH+1:2]];
            pc    <= fetch_pc;
        end
    end

    // program loading and fetching must not overlap
    a_no_load_while_fetching: assert property (
        @(posedge if_clk) disable iff (!arst_n)
        imem_we |-> !ce
    ) else $error("instruction memory written while ce is high");

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module regfile (
    input  logic                   rf_clk,
    input  logic                   arst_n,
    input  logic [`REG_AWIDTH-1:0] addr_rs1,
    input  logic [`REG_AWIDTH-1:0] addr_rs2,
    output logic [`XLEN-1:0]       data_rs1,
    output logic [`XLEN-1:0]       data_rs2,
    input  rv_pkg::wb_t            wb
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge rf_clk) begin
        if (wb.we && (wb.addr_rd != '0)) begin
            regs[wb.addr_rd] <= wb.data_rd;
        end
    end

    // combinational reads with bypass of the write landing this cycle
    always_comb begin
        if (addr_rs1 == '0) begin
            data_rs1 = '0;
        end else if (wb.we && (wb.addr_rd == addr_rs1)) begin
            data_rs1 = wb.data_rd;
        end else begin
            data_rs1 = regs[addr_rs1];
        end

        if (addr_rs2 == '0) begin
            data_rs2 = '0;
        end else if (wb.we && (wb.addr_rd == addr_rs2)) begin
            data_rs2 = wb.data_rd;
        end else begin
            data_rs2 = regs[addr_rs2];
        end
    end

    // execute already drops writes to x0
    a_no_x0_write: assert property (
        @(posedge rf_clk) disable iff (!arst_n)
        wb.we |-> (wb.addr_rd != '0)
    ) else $error("writeback targets x0");

endmodule

// File: hw/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // operations the execute stage alu knows
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLL    = 4'd6,
        SRL    = 4'd7,
        // operand b straight through, for lui
        PASS_B = 4'd8
    } alu_op_e;

    // decode to execute pipeline register
    typedef struct packed {
        logic                      valid;
        opcode_e                   opcode;
        alu_op_e                   alu_op;
        logic [`FUNCT3_WIDTH-1:0]  funct3;
        logic [`XLEN-1:0]          pc;
        logic [`XLEN-1:0]          imm;
        logic [`REG_AWIDTH-1:0]    addr_rs1;
        logic [`REG_AWIDTH-1:0]    addr_rs2;
        logic [`REG_AWIDTH-1:0]    addr_rd;
        logic [`XLEN-1:0]          data_rs1;
        logic [`XLEN-1:0]          data_rs2;
        logic                      use_imm;
    } ds_ex_t;

    // register file write from execute
    typedef struct packed {
        logic                   we;
        logic [`REG_AWIDTH-1:0] addr_rd;
        logic [`XLEN-1:0]       data_rd;
    } wb_t;

    // taken branch or jump back to fetch
    typedef struct packed {
        logic             change_pc;
        logic [`XLEN-1:0] next_pc;
    } redirect_t;

endpackage

// File: include/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and program counter width
`define XLEN 32

// register file addressing
`define REG_AWIDTH 5
`define NUM_REGS (1 << `REG_AWIDTH)

// instruction memory holds 2**IMEM_AWIDTH words
`define IMEM_AWIDTH 8
`define IMEM_DEPTH (1 << `IMEM_AWIDTH)

// byte distance between two sequential instructions
`define PC_STEP 4

// raw instruction field widths
`define OPCODE_WIDTH 7
`define FUNCT3_WIDTH 3
`define FUNCT7_WIDTH 7

// alu operation encoding width
`define ALU_OP_WIDTH 4

`endif
